/* logic/core_pkg.sv */
/*
  core package
  sizes, opcodes and packed structs shared by the out-of-order integer core
*/

package core_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////
  localparam int data_width    = 16;
  localparam int num_arch_regs = 8;
  localparam int num_phys_regs = 16;
  localparam int rob_depth     = 8;
  localparam int rs_depth      = 4;
  // tags not mapped after reset
  localparam int free_depth    = num_phys_regs - num_arch_regs;

  typedef logic [data_width-1:0]            data_t;
  typedef logic [$clog2(num_arch_regs)-1:0] arch_reg_t;
  typedef logic [$clog2(num_phys_regs)-1:0] phys_tag_t;
  typedef logic [$clog2(rob_depth)-1:0]     rob_idx_t;
  // one extra bit so a full rob can be counted
  typedef logic [$clog2(rob_depth):0]       rob_count_t;
  typedef logic [$clog2(rs_depth)-1:0]      rs_idx_t;
  typedef logic [$clog2(free_depth)-1:0]    free_idx_t;

  //////////////////////////////
  // opcodes
  //////////////////////////////
  typedef enum logic [2:0] {
    op_li,
    op_add,
    op_sub,
    op_and,
    op_xor
  } opcode_e;

  //////////////////////////////
  // pipeline payloads
  //////////////////////////////
  typedef struct packed {
    opcode_e   opcode;
    arch_reg_t dest;
    arch_reg_t src_a;
    arch_reg_t src_b;
    data_t     imm;
  } inst_t;

  // renamed instruction waiting in the rs
  typedef struct packed {
    opcode_e   opcode;
    phys_tag_t tag_a;
    logic      ready_a;
    phys_tag_t tag_b;
    logic      ready_b;
    data_t     imm;
    phys_tag_t dest_tag;
    rob_idx_t  rob_idx;
  } rs_entry_t;

  typedef struct packed {
    opcode_e   opcode;
    phys_tag_t tag_a;
    phys_tag_t tag_b;
    data_t     imm;
    phys_tag_t dest_tag;
    rob_idx_t  rob_idx;
  } issue_t;

  // single result bus
  typedef struct packed {
    logic      valid;
    phys_tag_t tag;
    rob_idx_t  rob_idx;
    data_t     value;
  } cdb_t;

  typedef struct packed {
    arch_reg_t arch_dest;
    phys_tag_t new_tag;
    phys_tag_t old_tag;
  } rob_alloc_t;

  typedef struct packed {
    arch_reg_t dest;
    data_t     value;
  } retire_t;

endpackage

/* logic/core_top.sv */
/*
  core top
  rename, reservation station, execute unit and reorder buffer
  joined by the dispatch, issue, cdb and free paths
*/
`timescale 1ns/1ps

module core_top (
  input  logic              clock,
  input  logic              reset,
  input  logic              inst_req,
  input  core_pkg::inst_t   inst,
  output logic              inst_ack,
  output logic              ret_valid,
  output core_pkg::retire_t ret
);

  // dispatch path
  logic                 dispatch_valid;
  core_pkg::rs_entry_t  rs_entry;
  core_pkg::rob_alloc_t rob_alloc;
  core_pkg::rob_idx_t   alloc_idx;
  logic                 rs_full;
  logic                 rob_full;

  // issue and result
  logic                 issue_valid;
  core_pkg::issue_t     issue;
  core_pkg::cdb_t       cdb;

  // tag recycling
  logic                 free_valid;
  core_pkg::phys_tag_t  free_tag;

  rename_stage u_rename (
    .clock          (clock),
    .reset          (reset),
    .inst_req       (inst_req),
    .inst           (inst),
    .rs_full        (rs_full),
    .rob_full       (rob_full),
    .alloc_idx      (alloc_idx),
    .cdb            (cdb),
    .free_valid     (free_valid),
    .free_tag       (free_tag),
    .inst_ack       (inst_ack),
    .dispatch_valid (dispatch_valid),
    .rs_entry       (rs_entry),
    .rob_alloc      (rob_alloc)
  );

  reservation_station u_rs (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .rs_entry       (rs_entry),
    .cdb            (cdb),
    .rs_full        (rs_full),
    .issue_valid    (issue_valid),
    .issue          (issue)
  );

  exec_unit u_exec (
    .clock          (clock),
    .reset          (reset),
    .issue_valid    (issue_valid),
    .issue          (issue),
    .cdb            (cdb)
  );

  reorder_buffer u_rob (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .rob_alloc      (rob_alloc),
    .cdb            (cdb),
    .alloc_idx      (alloc_idx),
    .rob_full       (rob_full),
    .ret_valid      (ret_valid),
    .ret            (ret),
    .free_valid     (free_valid),
    .free_tag       (free_tag)
  );

endmodule

/* logic/exec_unit.sv */
/*
  execute unit
  two-stage pipeline around the physical register file;
  stage one reads operands, stage two computes and drives the cdb
*/
`timescale 1ns/1ps

module exec_unit (
  input  logic             clock,
  input  logic             reset,
  input  logic             issue_valid,
  input  core_pkg::issue_t issue,
  output core_pkg::cdb_t   cdb
);

  core_pkg::data_t  prf [core_pkg::num_phys_regs];

  // stage one registers
  logic             s1_valid;
  core_pkg::issue_t s1_inst;
  core_pkg::data_t  s1_a;
  core_pkg::data_t  s1_b;

  core_pkg::data_t  rd_a;
  core_pkg::data_t  rd_b;
  core_pkg::data_t  alu_result;

  //////////////////////////////
  // operand read
  //////////////////////////////
  // bypass from the value written back on this edge
  always_comb begin
    rd_a = prf[issue.tag_a];
    rd_b = prf[issue.tag_b];
    if (s1_valid && s1_inst.dest_tag == issue.tag_a) begin
      rd_a = alu_result;
    end
    if (s1_valid && s1_inst.dest_tag == issue.tag_b) begin
      rd_b = alu_result;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= issue_valid;
    end
  end

  always_ff @(posedge clock) begin
    s1_inst <= issue;
    s1_a    <= rd_a;
    s1_b    <= rd_b;
  end

  //////////////////////////////
  // alu
  //////////////////////////////
  // 16 bit wrapping arithmetic
  always_comb begin
    unique case (s1_inst.opcode)
      core_pkg::op_li:  alu_result = s1_inst.imm;
      core_pkg::op_add: alu_result = s1_a + s1_b;
      core_pkg::op_sub: alu_result = s1_a - s1_b;
      core_pkg::op_and: alu_result = s1_a & s1_b;
      core_pkg::op_xor: alu_result = s1_a ^ s1_b;
      default:          alu_result = '0;
    endcase
  end

  //////////////////////////////
  // writeback and cdb
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      cdb.valid <= 1'b0;
      // mapped regs start at zero
      for (int i = 0; i < core_pkg::num_phys_regs; i++) begin
        prf[i] <= '0;
      end
    end else begin
      cdb.valid <= s1_valid;
      if (s1_valid) begin
        prf[s1_inst.dest_tag] <= alu_result;
      end
    end
  end

  // payload follows the valid bit
  always_ff @(posedge clock) begin
    cdb.tag     <= s1_inst.dest_tag;
    cdb.rob_idx <= s1_inst.rob_idx;
    cdb.value   <= alu_result;
  end

endmodule

/* logic/rename_stage.sv */
/*
  rename stage
  four-phase input handshake, map table, free list and tag ready table;
  turns each accepted instruction into an rs entry plus a rob allocation
*/
`timescale 1ns/1ps

module rename_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   inst_req,
  input  core_pkg::inst_t        inst,
  input  logic                   rs_full,
  input  logic                   rob_full,
  input  core_pkg::rob_idx_t     alloc_idx,
  input  core_pkg::cdb_t         cdb,
  input  logic                   free_valid,
  input  core_pkg::phys_tag_t    free_tag,
  output logic                   inst_ack,
  output logic                   dispatch_valid,
  output core_pkg::rs_entry_t    rs_entry,
  output core_pkg::rob_alloc_t   rob_alloc
);

  // arch to phys mapping
  core_pkg::phys_tag_t map_table [core_pkg::num_arch_regs];
  // one bit per phys tag, set once its value exists
  logic [core_pkg::num_phys_regs-1:0] tag_ready;
  // free tags in fifo order
  core_pkg::phys_tag_t free_list [core_pkg::free_depth];
  core_pkg::free_idx_t fl_head;
  core_pkg::free_idx_t fl_tail;

  logic                accept;
  logic                is_li;
  core_pkg::phys_tag_t new_tag;
  core_pkg::phys_tag_t tag_a;
  core_pkg::phys_tag_t tag_b;

  //////////////////////////////
  // handshake
  //////////////////////////////
  // take it only when both rs and rob have room
  assign accept         = inst_req && !inst_ack && !rs_full && !rob_full;
  assign dispatch_valid = accept;

  always_ff @(posedge clock) begin
    if (reset) begin
      inst_ack <= 1'b0;
    end else if (accept) begin
      inst_ack <= 1'b1;
    end else if (!inst_req) begin
      // drop one cycle after req falls
      inst_ack <= 1'b0;
    end
  end

  //////////////////////////////
  // lookup
  //////////////////////////////
  assign is_li   = (inst.opcode == core_pkg::op_li);
  assign new_tag = free_list[fl_head];
  assign tag_a   = map_table[inst.src_a];
  assign tag_b   = map_table[inst.src_b];

  always_comb begin
    rs_entry.opcode   = inst.opcode;
    rs_entry.tag_a    = tag_a;
    rs_entry.tag_b    = tag_b;
    // li needs no sources
    // a result on the cdb this cycle counts as ready
    rs_entry.ready_a  = is_li || tag_ready[tag_a] || (cdb.valid && cdb.tag == tag_a);
    rs_entry.ready_b  = is_li || tag_ready[tag_b] || (cdb.valid && cdb.tag == tag_b);
    rs_entry.imm      = inst.imm;
    rs_entry.dest_tag = new_tag;
    rs_entry.rob_idx  = alloc_idx;
  end

  // old mapping goes to the rob, freed at retire
  assign rob_alloc.arch_dest = inst.dest;
  assign rob_alloc.new_tag   = new_tag;
  assign rob_alloc.old_tag   = map_table[inst.dest];

  //////////////////////////////
  // tables
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map
      for (int i = 0; i < core_pkg::num_arch_regs; i++) begin
        map_table[i] <= core_pkg::phys_tag_t'(i);
      end
    end else if (accept) begin
      map_table[inst.dest] <= new_tag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // mapped tags hold zero and are ready
      tag_ready <= {{core_pkg::free_depth{1'b0}}, {core_pkg::num_arch_regs{1'b1}}};
    end else begin
      if (cdb.valid) begin
        tag_ready[cdb.tag] <= 1'b1;
      end
      // fresh dest tag waits for its result
      if (accept) begin
        tag_ready[new_tag] <= 1'b0;
      end
    end
  end

  // free list starts full with the upper tags
  // pop and push can happen on the same edge
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < core_pkg::free_depth; i++) begin
        free_list[i] <= core_pkg::phys_tag_t'(core_pkg::num_arch_regs + i);
      end
      fl_head <= '0;
      fl_tail <= '0;
    end else begin
      if (accept) begin
        fl_head <= fl_head + 1'b1;
      end
      if (free_valid) begin
        free_list[fl_tail] <= free_tag;
        fl_tail            <= fl_tail + 1'b1;
      end
    end
  end

endmodule

/* logic/reorder_buffer.sv */
/*
  reorder buffer
  circular buffer of in-flight instructions; records completion from the
  cdb and retires the head in program order, freeing its old tag
*/
`timescale 1ns/1ps

module reorder_buffer (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 dispatch_valid,
  input  core_pkg::rob_alloc_t rob_alloc,
  input  core_pkg::cdb_t       cdb,
  output core_pkg::rob_idx_t   alloc_idx,
  output logic                 rob_full,
  output logic                 ret_valid,
  output core_pkg::retire_t    ret,
  output logic                 free_valid,
  output core_pkg::phys_tag_t  free_tag
);

  core_pkg::rob_alloc_t          info [core_pkg::rob_depth];
  core_pkg::data_t               result [core_pkg::rob_depth];
  logic [core_pkg::rob_depth-1:0] done;

  core_pkg::rob_idx_t            head;
  core_pkg::rob_idx_t            tail;
  core_pkg::rob_count_t          count;
  logic                          retire_go;

  assign alloc_idx = tail;
  assign rob_full  = (count == core_pkg::rob_count_t'(core_pkg::rob_depth));

  //////////////////////////////
  // retire
  //////////////////////////////
  // head leaves once its result is in
  assign retire_go = (count != '0) && done[head];

  assign ret_valid  = retire_go;
  assign ret.dest   = info[head].arch_dest;
  assign ret.value  = result[head];
  // old tag goes back to rename on the same edge
  assign free_valid = retire_go;
  assign free_tag   = info[head].old_tag;

  //////////////////////////////
  // pointers
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (dispatch_valid) begin
        tail <= tail + 1'b1;
      end
      if (retire_go) begin
        head <= head + 1'b1;
      end
      case ({dispatch_valid, retire_go})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  //////////////////////////////
  // completion
  //////////////////////////////
  // a result on the cdb marks its slot done
  always_ff @(posedge clock) begin
    if (reset) begin
      done <= '0;
    end else begin
      if (cdb.valid) begin
        done[cdb.rob_idx] <= 1'b1;
      end
      // slot reused at the tail starts pending
      if (dispatch_valid) begin
        done[tail] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (dispatch_valid) begin
      info[tail] <= rob_alloc;
    end
    if (cdb.valid) begin
      result[cdb.rob_idx] <= cdb.value;
    end
  end

endmodule

/* logic/reservation_station.sv */
/*
  reservation station
  holds renamed instructions in age order, wakes operands from the cdb
  and issues the oldest ready entry each cycle
*/
`timescale 1ns/1ps

module reservation_station (
  input  logic                clock,
  input  logic                reset,
  input  logic                dispatch_valid,
  input  core_pkg::rs_entry_t rs_entry,
  input  core_pkg::cdb_t      cdb,
  output logic                rs_full,
  output logic                issue_valid,
  output core_pkg::issue_t    issue
);

  // slot 0 is always the oldest
  // valid bits stay packed toward slot 0
  core_pkg::rs_entry_t              slots [core_pkg::rs_depth];
  logic [core_pkg::rs_depth-1:0]    slot_valid;

  core_pkg::rs_entry_t              woken [core_pkg::rs_depth];
  core_pkg::rs_entry_t              next_slots [core_pkg::rs_depth];
  logic [core_pkg::rs_depth-1:0]    next_valid;
  logic                             pick_found;
  core_pkg::rs_idx_t                pick_idx;
  logic                             ins_done;

  // top slot in use means every slot is
  assign rs_full = slot_valid[core_pkg::rs_depth-1];

  //////////////////////////////
  // wakeup and select
  //////////////////////////////
  always_comb begin
    pick_found = 1'b0;
    pick_idx   = '0;
    for (int i = 0; i < core_pkg::rs_depth; i++) begin
      woken[i] = slots[i];
      // tag compare against both operands
      if (cdb.valid && cdb.tag == slots[i].tag_a) begin
        woken[i].ready_a = 1'b1;
      end
      if (cdb.valid && cdb.tag == slots[i].tag_b) begin
        woken[i].ready_b = 1'b1;
      end
    end
    // scan downward so the lowest ready slot wins
    for (int i = core_pkg::rs_depth - 1; i >= 0; i--) begin
      if (slot_valid[i] && woken[i].ready_a && woken[i].ready_b) begin
        pick_found = 1'b1;
        pick_idx   = core_pkg::rs_idx_t'(i);
      end
    end
  end

  //////////////////////////////
  // compact and insert
  //////////////////////////////
  always_comb begin
    ins_done = 1'b0;
    for (int i = 0; i < core_pkg::rs_depth; i++) begin
      if (pick_found && i >= int'(pick_idx)) begin
        // close the gap left by the issued entry
        if (i < core_pkg::rs_depth - 1) begin
          next_slots[i] = woken[i + 1];
          next_valid[i] = slot_valid[i + 1];
        end else begin
          next_slots[i] = woken[i];
          next_valid[i] = 1'b0;
        end
      end else begin
        next_slots[i] = woken[i];
        next_valid[i] = slot_valid[i];
      end
    end
    // new entry behind everything already held
    for (int i = 0; i < core_pkg::rs_depth; i++) begin
      if (dispatch_valid && !ins_done && !next_valid[i]) begin
        next_slots[i] = rs_entry;
        next_valid[i] = 1'b1;
        ins_done      = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      slot_valid <= '0;
    end else begin
      slot_valid <= next_valid;
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < core_pkg::rs_depth; i++) begin
      slots[i] <= next_slots[i];
    end
  end

  //////////////////////////////
  // issue register
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= pick_found;
    end
  end

  always_ff @(posedge clock) begin
    issue.opcode   <= woken[pick_idx].opcode;
    issue.tag_a    <= woken[pick_idx].tag_a;
    issue.tag_b    <= woken[pick_idx].tag_b;
    issue.imm      <= woken[pick_idx].imm;
    issue.dest_tag <= woken[pick_idx].dest_tag;
    issue.rob_idx  <= woken[pick_idx].rob_idx;
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the core testbench with verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary -f vlog.f --top-module core_tb -Mdir obj_dir -o core_sim \
  > build.log 2>&1 \
  && ./obj_dir/core_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -qx "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* verif/core_tb.sv */
/*
  core testbench
  drives the out-of-order core over its four-phase input handshake with
  lfsr stimulus and checks every retirement against a sequential model
*/
`timescale 1ns/1ps

module core_tb;

  //////////////////////////////
  // run length
  //////////////////////////////
  localparam int clock_period  = 8;
  localparam int reset_cycles  = 16;
  // sample point after the rising edge, well before the falling one
  localparam int sample_delay  = 2;
  localparam int num_li        = 8;
  localparam int chain_len     = 24;
  localparam int num_random    = 200;
  localparam int total_insts   = num_li + chain_len + num_random;
  localparam int timeout_cycles = reset_cycles + 200 * total_insts;

  logic              clock;
  logic              reset;
  logic              inst_req;
  core_pkg::inst_t   inst;
  logic              inst_ack;
  logic              ret_valid;
  core_pkg::retire_t ret;

  // sequential model state
  core_pkg::data_t   arch_model [core_pkg::num_arch_regs];
  core_pkg::retire_t expected_q [$];
  core_pkg::retire_t exp_ret;
  logic [31:0]       lfsr_state;

  int                error_count;
  int                sent_count;
  int                accepted_count;
  int                retired_count;
  // cycles a request waited on a full rs or rob
  int                stall_cycles;
  logic              req_seen;
  logic              prev_ack;

  core_pkg::inst_t   next_inst;
  logic [31:0]       bits;
  logic [31:0]       op_num;
  core_pkg::arch_reg_t prev_dest;

  core_top u_dut (
    .clock     (clock),
    .reset     (reset),
    .inst_req  (inst_req),
    .inst      (inst),
    .inst_ack  (inst_ack),
    .ret_valid (ret_valid),
    .ret       (ret)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////
  // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // executes in program order with 16 bit wrap
  function automatic core_pkg::retire_t model_exec(input core_pkg::inst_t i);
    core_pkg::data_t   a;
    core_pkg::data_t   b;
    core_pkg::data_t   value;
    core_pkg::retire_t r;
    a = arch_model[i.src_a];
    b = arch_model[i.src_b];
    case (i.opcode)
      core_pkg::op_li:  value = i.imm;
      core_pkg::op_add: value = a + b;
      core_pkg::op_sub: value = a - b;
      core_pkg::op_and: value = a & b;
      core_pkg::op_xor: value = a ^ b;
      default:          value = '0;
    endcase
    arch_model[i.dest] = value;
    r.dest  = i.dest;
    r.value = value;
    return r;
  endfunction

  // full four-phase transfer starting on a falling edge
  task automatic send_inst(input core_pkg::inst_t i, input int gap);
    expected_q.push_back(model_exec(i));
    sent_count++;
    inst     = i;
    inst_req = 1'b1;
    @(negedge clock);
    while (!inst_ack) begin
      stall_cycles++;
      @(negedge clock);
    end
    inst_req = 1'b0;
    @(negedge clock);
    while (inst_ack) begin
      @(negedge clock);
    end
    repeat (gap) @(negedge clock);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    reset          = 1'b1;
    inst_req       = 1'b0;
    inst           = '0;
    lfsr_state     = 32'hd8ac1642;
    error_count    = 0;
    sent_count     = 0;
    accepted_count = 0;
    retired_count  = 0;
    stall_cycles   = 0;
    req_seen       = 1'b0;
    prev_ack       = 1'b0;
    prev_dest      = '0;
    for (int r = 0; r < core_pkg::num_arch_regs; r++) begin
      arch_model[r] = '0;
    end
    repeat (reset_cycles) @(negedge clock);
    reset = 1'b0;
    // quiet window before the first request
    repeat (4) @(negedge clock);

    // li into every register with random gaps
    for (int k = 0; k < num_li; k++) begin
      bits             = take_bits(16);
      next_inst.opcode = core_pkg::op_li;
      next_inst.dest   = core_pkg::arch_reg_t'(k);
      next_inst.src_a  = '0;
      next_inst.src_b  = '0;
      next_inst.imm    = bits[15:0];
      send_inst(next_inst, int'(take_bits(2)));
    end

    // dependent chain where each src_a is the previous dest
    for (int k = 0; k < chain_len; k++) begin
      op_num           = take_bits(2) + 32'd1;
      next_inst.opcode = core_pkg::opcode_e'(op_num[2:0]);
      next_inst.src_a  = prev_dest;
      bits             = take_bits(3);
      next_inst.src_b  = bits[2:0];
      bits             = take_bits(3);
      next_inst.dest   = bits[2:0];
      bits             = take_bits(16);
      next_inst.imm    = bits[15:0];
      prev_dest        = next_inst.dest;
      send_inst(next_inst, 0);
    end

    // random mix with no gaps to fill rs and rob
    for (int k = 0; k < num_random; k++) begin
      op_num           = take_bits(3) % 32'd5;
      next_inst.opcode = core_pkg::opcode_e'(op_num[2:0]);
      bits             = take_bits(3);
      next_inst.dest   = bits[2:0];
      bits             = take_bits(3);
      next_inst.src_a  = bits[2:0];
      bits             = take_bits(3);
      next_inst.src_b  = bits[2:0];
      bits             = take_bits(16);
      next_inst.imm    = bits[15:0];
      send_inst(next_inst, 0);
    end

    // wait for every expected retirement
    while (expected_q.size() != 0) begin
      @(negedge clock);
    end
    // catch stray retirements
    repeat (20) @(negedge clock);

    if (accepted_count != sent_count) begin
      $display("%0d instructions sent but %0d accepted", sent_count, accepted_count);
      error_count++;
    end
    if (retired_count != accepted_count) begin
      $display("%0d instructions accepted but %0d retired", accepted_count, retired_count);
      error_count++;
    end
    if (stall_cycles == 0) begin
      $display("no request was ever held off by a full rs or rob");
      error_count++;
    end
    $display("errors: %0d  sent: %0d  accepted: %0d  retired: %0d  stalls: %0d",
             error_count, sent_count, accepted_count, retired_count, stall_cycles);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  //////////////////////////////
  // checkers
  //////////////////////////////
  // retirement compare against the model queue
  always @(posedge clock) begin
    #sample_delay;
    if (!reset && ret_valid) begin
      retired_count++;
      if (expected_q.size() == 0) begin
        $display("ret_valid at %0t with no instruction outstanding", $time);
        error_count++;
      end else begin
        exp_ret = expected_q.pop_front();
        if (ret.dest !== exp_ret.dest) begin
          $display("FAIL t=%0t ret.dest expected %0d got %0d",
                   $time, exp_ret.dest, ret.dest);
          error_count++;
        end
        if (ret.value !== exp_ret.value) begin
          $display("FAIL t=%0t ret.value expected 0x%04h got 0x%04h",
                   $time, exp_ret.value, ret.value);
          error_count++;
        end
      end
    end
  end

  // handshake rules on req as sampled after the edge
  always @(posedge clock) begin
    #sample_delay;
    if (!reset) begin
      if (inst_req) begin
        req_seen = 1'b1;
      end
      if (!req_seen && (inst_ack || ret_valid)) begin
        $display("core active at %0t before any request was made", $time);
        error_count++;
      end
      if (inst_ack && !prev_ack) begin
        accepted_count++;
        if (!inst_req) begin
          $display("inst_ack rose at %0t while inst_req was low", $time);
          error_count++;
        end
      end
      if (!inst_ack && prev_ack && inst_req) begin
        $display("inst_ack fell at %0t while inst_req was still high", $time);
        error_count++;
      end
      prev_ack = inst_ack;
    end
  end

  // watchdog
  initial begin
    repeat (timeout_cycles) @(posedge clock);
    $display("timeout after %0d cycles with %0d of %0d instructions retired",
             timeout_cycles, retired_count, total_insts);
    $display("Something failed");
    $finish;
  end

endmodule

/* vlog.f */
logic/core_pkg.sv
logic/rename_stage.sv
logic/reservation_station.sv
logic/exec_unit.sv
logic/reorder_buffer.sv
logic/core_top.sv
verif/core_tb.sv
